// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = dac_subsystem_tb
FILELIST = sim.f
BUILD    = obj_dir
LOG      = sim.log
PASS_MSG = Simulation finished: PASS

SOURCES  = $(shell cat $(FILELIST))

.PHONY: all compile run check clean

all: check

compile: $(BUILD)/V$(TOP)

$(BUILD)/V$(TOP): $(FILELIST) $(SOURCES)
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: compile
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)

check: run
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }
	@echo "simulation passed"

clean:
	rm -rf $(BUILD) $(LOG)

// ==== bench/dac_stimulus.txt ====
# op arg value (hex) : write addr data, read addr expected, gain value 0, rgain count base
# op arg value (hex) : enable level 0, frame 0 expected_word, idle quiet_cycles frames_left
frame  0  2000
idle   14 0
enable 1  0
read   0  0001
read   1  2000
read   2  0001
read   3  0000
write  1  c0a5
frame  0  c0a5
read   1  c0a5
gain   5a 0
idle   28 0
read   1  c0a5
write  0  7777
write  3  5555
idle   28 0
read   0  0001
enable 0  0
read   2  0000
gain   3c 0
frame  0  cf25
write  1  1234
idle   28 0
read   1  cf25
rgain  4  cf25
enable 1  0
write  1  1111
write  1  2222
write  1  3333
write  1  4444
frame  0  1111
frame  0  4444
idle   28 0
read   1  4444

// ==== bench/dac_subsystem_tb.sv ====
////////////////////////////////////////////////////////////////////////////
// testbench for the DAC subsystem that runs the command list in the stimulus
// file and checks serial frames, register reads and status strobes
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module dac_subsystem_tb
    import dac_pkg::*;
();

    typedef logic [8*16-1:0] token_t;

    localparam string STIM_FILE    = "bench/dac_stimulus.txt";
    localparam int    RESET_CYCLES = 16;
    localparam int    FRAME_CYCLES = 2 * SCLK_HALF * FRAME_BITS + 10;
    localparam int    OP_BAD = 0, OP_WRITE = 1, OP_READ = 2, OP_GAIN = 3, OP_RGAIN = 4;
    localparam int    OP_ENABLE = 5, OP_FRAME = 6, OP_IDLE = 7;

    logic      clk, peripheral_sreset;
    logic      wvalid, wready, arvalid, arready, rvalid, rready;
    mmi_addr_t waddr, raddr;
    mmi_data_t wdata, rdata;
    logic      en_mmi_ctrl, gain_stb;
    gain_t     gain;
    logic      sclk, sync_n, sdin, initdone, dac_updated_stb;

    int          cmd_op[$];
    logic [31:0] cmd_arg[$];
    logic [31:0] cmd_val[$];
    dac_word_t   frames[$];
    int          frame_total, upd_count, error_count, check_count;
    int          watch_limit, frames_planned, idle_planned;

    tb_clock_gen clock_i (.clk(clk));

    dac_subsystem_top dac_subsystem_top_i (.*);

    ////////////////////////////////////////////////////////////////////////////
    // compare tasks

    task automatic check_word(input string what, input dac_word_t got, input dac_word_t exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("Error at %0t ns: %s got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_data(input string what, input mmi_data_t got, input mmi_data_t exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("Error at %0t ns: %s got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("Error at %0t ns: %s got %b, expected %b", $time, what, got, exp);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // frame monitor on the DAC side, which latches sdin on falling sclk

    logic      sclk_prev;
    dac_word_t frame_shift;
    int        bit_count;

    always @(negedge clk) begin
        if (peripheral_sreset) begin
            bit_count = 0;
        end else begin
            if (sync_n) begin
                bit_count = 0;
            end else if (sclk_prev && !sclk) begin
                frame_shift = {frame_shift[FRAME_BITS-2:0], sdin};
                bit_count++;
                if (bit_count == FRAME_BITS) begin
                    frames.push_back(frame_shift);
                    frame_total++;
                    bit_count = 0;
                end
            end
            // initdone rises together with the first update strobe
            check_bit("initdone", initdone, (upd_count > 0) || dac_updated_stb);
            if (dac_updated_stb) begin
                upd_count++;
            end
        end
        sclk_prev = sclk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // bus and strobe drivers for the falling edge

    task automatic write_reg(input mmi_addr_t addr, input mmi_data_t data);
        wvalid = 1'b1;
        waddr  = addr;
        wdata  = data;
        while (!wready) @(negedge clk);
        @(negedge clk);
        wvalid = 1'b0;
    endtask

    task automatic read_reg(input mmi_addr_t addr, input mmi_data_t exp);
        arvalid = 1'b1;
        raddr   = addr;
        while (!arready) @(negedge clk);
        @(negedge clk);
        arvalid = 1'b0;
        while (!rvalid) @(negedge clk);
        check_data("read data", rdata, exp);
        // rready stays low so the held value can be watched
        repeat (4) begin
            @(negedge clk);
            check_bit("rvalid held", rvalid, 1'b1);
            check_bit("arready while rvalid", arready, 1'b0);
            check_data("held read data", rdata, exp);
        end
        rready = 1'b1;
        @(negedge clk);
        rready = 1'b0;
        check_bit("rvalid after rready", rvalid, 1'b0);
        check_bit("arready after rready", arready, 1'b1);
    endtask

    task automatic strobe_gain(input gain_t value);
        gain     = value;
        gain_stb = 1'b1;
        @(negedge clk);
        gain_stb = 1'b0;
    endtask

    task automatic wait_frame(input dac_word_t exp);
        while (frames.size() == 0) @(negedge clk);
        check_word("serial frame", frames.pop_front(), exp);
    endtask

    task automatic wait_idle(input int quiet_cycles, input int frames_left);
        int quiet;
        quiet = 0;
        while (quiet < quiet_cycles) begin
            @(negedge clk);
            if (sync_n && !dac_updated_stb) quiet++;
            else quiet = 0;
        end
        if (frames.size() != frames_left) begin
            error_count++;
            $display("Error at %0t ns: %0d frames unclaimed, expected %0d", $time,
                     frames.size(), frames_left);
        end
        if (upd_count != frame_total) begin
            error_count++;
            $display("Error at %0t ns: %0d update strobes for %0d frames", $time,
                     upd_count, frame_total);
        end
    endtask

    // mode bits 15:14 and reserved bits 5:0 survive a gain update
    function automatic dac_word_t merge_gain(input dac_word_t w, input gain_t g);
        merge_gain = {w[15:14], g, w[5:0]};
    endfunction

    task automatic random_gains(input int count, input dac_word_t base);
        dac_word_t expected;
        gain_t     value;
        expected = base;
        for (int i = 0; i < count; i++) begin
            value    = gain_t'($urandom);
            expected = merge_gain(expected, value);
            strobe_gain(value);
            wait_frame(expected);
        end
        // the last frame ends before the next command so that starts from idle
        while (!dac_updated_stb) @(negedge clk);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // stimulus file

    function automatic int decode_op(input token_t t);
        if (t == token_t'("write"))  return OP_WRITE;
        if (t == token_t'("read"))   return OP_READ;
        if (t == token_t'("gain"))   return OP_GAIN;
        if (t == token_t'("rgain"))  return OP_RGAIN;
        if (t == token_t'("enable")) return OP_ENABLE;
        if (t == token_t'("frame"))  return OP_FRAME;
        if (t == token_t'("idle"))   return OP_IDLE;
        return OP_BAD;
    endfunction

    function automatic string op_name(input int op);
        case (op)
            OP_WRITE:  return "write";
            OP_READ:   return "read";
            OP_GAIN:   return "gain";
            OP_RGAIN:  return "rgain";
            OP_ENABLE: return "enable";
            OP_FRAME:  return "frame";
            OP_IDLE:   return "idle";
            default:   return "unknown";
        endcase
    endfunction

    task automatic load_stimulus();
        int               fd;
        int               code;
        int               op;
        token_t           token;
        logic [31:0]      arg;
        logic [31:0]      val;
        logic [8*160-1:0] rest;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            error_count++;
            $display("could not open the stimulus file %s", STIM_FILE);
            return;
        end
        while (!$feof(fd)) begin
            code = $fscanf(fd, "%s", token);
            if (code == 1 && token == token_t'("#")) begin
                code = $fgets(rest, fd);
            end else if (code == 1) begin
                code = $fscanf(fd, "%h %h", arg, val);
                op   = decode_op(token);
                if (code != 2 || op == OP_BAD) begin
                    error_count++;
                    $display("a stimulus line could not be understood: %0s", token);
                end else begin
                    cmd_op.push_back(op);
                    cmd_arg.push_back(arg);
                    cmd_val.push_back(val);
                    if (op == OP_FRAME) frames_planned++;
                    if (op == OP_RGAIN) frames_planned += int'(arg);
                    if (op == OP_IDLE)  idle_planned += int'(arg);
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic run_command(input int idx);
        logic [31:0] arg;
        logic [31:0] val;
        arg = cmd_arg[idx];
        val = cmd_val[idx];
        case (cmd_op[idx])
            OP_WRITE:  write_reg(mmi_addr_t'(arg), mmi_data_t'(val));
            OP_READ:   read_reg(mmi_addr_t'(arg), mmi_data_t'(val));
            OP_GAIN:   strobe_gain(gain_t'(arg));
            OP_RGAIN:  random_gains(int'(arg), dac_word_t'(val));
            OP_ENABLE: en_mmi_ctrl = arg[0];
            OP_FRAME:  wait_frame(dac_word_t'(val));
            OP_IDLE:   wait_idle(int'(arg), int'(val));
            default:   error_count++;
        endcase
        @(negedge clk);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // watchdog

    initial begin
        wait (watch_limit > 0);
        repeat (watch_limit) @(posedge clk);
        $display("timeout: the run did not finish within %0d clock cycles", watch_limit);
        $display("Simulation finished: FAIL");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////////////
    // main sequence

    initial begin
        int unsigned seed;
        int          failed_tests;
        int          errors_before;
        peripheral_sreset = 1'b1;
        wvalid      = 1'b0;
        waddr       = '0;
        wdata       = '0;
        arvalid     = 1'b0;
        raddr       = '0;
        rready      = 1'b0;
        en_mmi_ctrl = 1'b1;
        gain        = '0;
        gain_stb    = 1'b0;
        failed_tests = 0;
        seed = $urandom(32'h1056);

        load_stimulus();
        watch_limit = (frames_planned + 1) * FRAME_CYCLES + idle_planned
                    + 50 * cmd_op.size() + RESET_CYCLES + 500;

        // idle pin levels are checked in the last reset cycle
        repeat (RESET_CYCLES) @(negedge clk);
        errors_before = error_count;
        check_bit("sync_n in reset", sync_n, 1'b1);
        check_bit("sclk in reset", sclk, 1'b1);
        check_bit("initdone in reset", initdone, 1'b0);
        check_bit("dac_updated_stb in reset", dac_updated_stb, 1'b0);
        check_bit("wready in reset", wready, 1'b0);
        check_bit("arready in reset", arready, 1'b0);
        check_bit("rvalid in reset", rvalid, 1'b0);
        peripheral_sreset = 1'b0;
        if (error_count != errors_before) failed_tests++;
        $display("test 0 reset %s", (error_count == errors_before) ? "ok" : "FAILED");

        for (int i = 0; i < cmd_op.size(); i++) begin
            errors_before = error_count;
            run_command(i);
            if (error_count != errors_before) failed_tests++;
            $display("test %0d %s %s", i + 1, op_name(cmd_op[i]),
                     (error_count == errors_before) ? "ok" : "FAILED");
        end

        $display("tests %0d, failed %0d, checks %0d, errors %0d, frames %0d",
                 cmd_op.size() + 1, failed_tests, check_count, error_count, frame_total);
        if (error_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== bench/tb_clock_gen.sv ====
////////////////////////////////////////////////////////////////////////////
// free-running 4 ns testbench clock, low at time zero
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen (
    output var logic clk
);

    localparam int HALF_PERIOD = 2;

    initial clk = 1'b0;

    always #HALF_PERIOD clk = ~clk;

endmodule

`default_nettype wire

// ==== design/dac_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// shared widths, register addresses and serial timing for the DAC control
// subsystem, imported by every design block and the testbench
////////////////////////////////////////////////////////////////////////////

`default_nettype none

package dac_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // data types

    // full word shifted into the AD5601
    typedef logic [15:0] dac_word_t;
    // data field of the DAC word
    typedef logic [7:0]  gain_t;
    // register port
    typedef logic [1:0]  mmi_addr_t;
    typedef logic [15:0] mmi_data_t;

    ////////////////////////////////////////////////////////////////////////////
    // register map

    localparam mmi_addr_t ADDR_VERSION  = 2'd0;
    localparam mmi_addr_t ADDR_DAC_WORD = 2'd1;
    localparam mmi_addr_t ADDR_EN_CTRL  = 2'd2;
    localparam int        NUM_REGS      = 3;

    localparam mmi_data_t MODULE_VERSION = 16'd1;

    // mode 00 (normal operation), data at mid scale, reserved bits zero
    localparam dac_word_t DAC_DEFAULT = {2'b00, 8'h80, 6'b000000};

    // data field sits at bits 13:6
    localparam int GAIN_LSB = 6;

    ////////////////////////////////////////////////////////////////////////////
    // serial timing

    // clk cycles per sclk half period
    localparam int SCLK_HALF  = 4;
    localparam int FRAME_BITS = 16;

    // counter widths for the shifter
    localparam int SCLK_CNT_W = $clog2(SCLK_HALF);
    localparam int BIT_CNT_W  = $clog2(FRAME_BITS);

endpackage

`default_nettype wire

// ==== design/dac_reg_file.sv ====
////////////////////////////////////////////////////////////////////////////
// register map for the DAC subsystem: version, DAC word and enable flag,
// with the gain merge path and the strobe that marks each word update
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module dac_reg_file
    import dac_pkg::*;
(
    input  var logic      clk,
    input  var logic      peripheral_sreset,

    input  var logic      en_mmi_ctrl,
    input  var gain_t     gain,
    input  var logic      gain_stb,

    input  var logic      wvalid,
    output var logic      wready,
    input  var mmi_addr_t waddr,
    input  var mmi_data_t wdata,

    input  var logic      arvalid,
    output var logic      arready,
    input  var mmi_addr_t raddr,
    output var logic      rvalid,
    input  var logic      rready,
    output var mmi_data_t rdata,

    output var dac_word_t word,
    output var logic      word_stb
);

    logic      port_ready;
    dac_word_t dac_reg;
    logic      wr_dac;
    logic      gain_merge;

    // register read mux, anything past the map reads as zero
    function automatic mmi_data_t read_value(input mmi_addr_t addr);
        read_value = '0;
        if (addr < NUM_REGS) begin
            case (addr)
                ADDR_VERSION:  read_value = MODULE_VERSION;
                ADDR_DAC_WORD: read_value = dac_reg;
                ADDR_EN_CTRL:  read_value = mmi_data_t'(en_mmi_ctrl);
                default:       read_value = '0;
            endcase
        end
    endfunction

    assign wready  = port_ready;
    assign arready = port_ready & ~rvalid;
    assign word    = dac_reg;

    // only the DAC word is writable, and only when the port owns it
    assign wr_dac     = wvalid & port_ready & en_mmi_ctrl & (waddr == ADDR_DAC_WORD);
    assign gain_merge = gain_stb & ~en_mmi_ctrl;

    ////////////////////////////////////////////////////////////////////////////
    // port handshake

    always_ff @(posedge clk) begin
        if (peripheral_sreset) begin
            port_ready <= 1'b0;
        end else begin
            port_ready <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (peripheral_sreset) begin
            rvalid <= 1'b0;
        end else if (arvalid && arready) begin
            rvalid <= 1'b1;
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

    // read data is captured with the address and held until rready
    always_ff @(posedge clk) begin
        if (arvalid && arready) begin
            rdata <= read_value(raddr);
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // DAC word

    always_ff @(posedge clk) begin
        if (peripheral_sreset) begin
            dac_reg  <= DAC_DEFAULT;
            word_stb <= 1'b0;
        end else begin
            word_stb <= wr_dac | gain_merge;
            if (wr_dac) begin
                dac_reg <= wdata;
            end else if (gain_merge) begin
                // mode and reserved bits are kept
                dac_reg[GAIN_LSB +: $bits(gain_t)] <= gain;
            end
        end
    end

    rdata_hold_a: assert property (@(posedge clk) disable iff (peripheral_sreset)
        rvalid && !rready |=> $stable(rdata));

endmodule

`default_nettype wire

// ==== design/dac_spi_shifter.sv ====
////////////////////////////////////////////////////////////////////////////
// 16-bit serial shifter for the AD5601: sync_n framing, idle-high sclk,
// data launched on sclk rise so the DAC samples it on the fall
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module dac_spi_shifter
    import dac_pkg::*;
(
    input  var logic      clk,
    input  var logic      peripheral_sreset,

    input  var logic      start,
    input  var dac_word_t tx_word,
    output var logic      busy,
    output var logic      done,

    output var logic      sclk,
    output var logic      sync_n,
    output var logic      sdin
);

    dac_word_t             shreg;
    logic [SCLK_CNT_W-1:0] div_cnt;
    logic [BIT_CNT_W-1:0]  bit_cnt;
    logic                  shifting;
    logic                  half_tick;

    // busy with sync_n high is the single tail cycle before done
    assign shifting  = busy & ~sync_n;
    assign half_tick = (div_cnt == SCLK_CNT_W'(SCLK_HALF - 1));

    // msb first
    assign sdin = shreg[FRAME_BITS-1];

    always_ff @(posedge clk) begin
        if (peripheral_sreset) begin
            busy    <= 1'b0;
            done    <= 1'b0;
            sync_n  <= 1'b1;
            sclk    <= 1'b1;
            div_cnt <= '0;
            bit_cnt <= '0;
        end else begin
            done <= 1'b0;
            if (!busy) begin
                if (start) begin
                    busy    <= 1'b1;
                    sync_n  <= 1'b0;
                    div_cnt <= '0;
                    bit_cnt <= '0;
                end
            end else if (shifting) begin
                if (half_tick) begin
                    div_cnt <= '0;
                    sclk    <= ~sclk;
                    // rising edge closes one bit period
                    if (!sclk) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == BIT_CNT_W'(FRAME_BITS - 1)) begin
                            sync_n <= 1'b1;
                        end
                    end
                end else begin
                    div_cnt <= div_cnt + 1'b1;
                end
            end else begin
                busy <= 1'b0;
                done <= 1'b1;
            end
        end
    end

    // next bit moves onto sdin with the rising sclk
    always_ff @(posedge clk) begin
        if (!busy && start) begin
            shreg <= tx_word;
        end else if (shifting && half_tick && !sclk) begin
            shreg <= {shreg[FRAME_BITS-2:0], 1'b0};
        end
    end

    frame_busy_a: assert property (@(posedge clk) disable iff (peripheral_sreset)
        !sync_n |-> busy);

endmodule

`default_nettype wire

// ==== design/dac_subsystem_top.sv ====
////////////////////////////////////////////////////////////////////////////
// AD5601 control subsystem top: register file, transfer control, shifter
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module dac_subsystem_top
    import dac_pkg::*;
(
    input  var logic      clk,
    input  var logic      peripheral_sreset,

    // register write port
    input  var logic      wvalid,
    output var logic      wready,
    input  var mmi_addr_t waddr,
    input  var mmi_data_t wdata,

    // register read port
    input  var logic      arvalid,
    output var logic      arready,
    input  var mmi_addr_t raddr,
    output var logic      rvalid,
    input  var logic      rready,
    output var mmi_data_t rdata,

    input  var logic      en_mmi_ctrl,
    input  var gain_t     gain,
    input  var logic      gain_stb,

    // DAC pins
    output var logic      sclk,
    output var logic      sync_n,
    output var logic      sdin,

    output var logic      initdone,
    output var logic      dac_updated_stb
);

    dac_word_t word;
    logic      word_stb;
    logic      start;
    dac_word_t tx_word;
    logic      busy;
    logic      done;

    dac_reg_file dac_reg_file_i (
        .clk               (clk),
        .peripheral_sreset (peripheral_sreset),
        .en_mmi_ctrl       (en_mmi_ctrl),
        .gain              (gain),
        .gain_stb          (gain_stb),
        .wvalid            (wvalid),
        .wready            (wready),
        .waddr             (waddr),
        .wdata             (wdata),
        .arvalid           (arvalid),
        .arready           (arready),
        .raddr             (raddr),
        .rvalid            (rvalid),
        .rready            (rready),
        .rdata             (rdata),
        .word              (word),
        .word_stb          (word_stb)
    );

    dac_xfer_ctrl dac_xfer_ctrl_i (
        .clk               (clk),
        .peripheral_sreset (peripheral_sreset),
        .word              (word),
        .word_stb          (word_stb),
        .busy              (busy),
        .done              (done),
        .start             (start),
        .tx_word           (tx_word),
        .initdone          (initdone),
        .dac_updated_stb   (dac_updated_stb)
    );

    dac_spi_shifter dac_spi_shifter_i (
        .clk               (clk),
        .peripheral_sreset (peripheral_sreset),
        .start             (start),
        .tx_word           (tx_word),
        .busy              (busy),
        .done              (done),
        .sclk              (sclk),
        .sync_n            (sync_n),
        .sdin              (sdin)
    );

endmodule

`default_nettype wire

// ==== design/dac_xfer_ctrl.sv ====
////////////////////////////////////////////////////////////////////////////
// transfer sequencing: default frame after reset, one frame per word change
// and a single merged follow-up for changes that land mid-frame
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module dac_xfer_ctrl
    import dac_pkg::*;
(
    input  var logic      clk,
    input  var logic      peripheral_sreset,

    input  var dac_word_t word,
    input  var logic      word_stb,

    input  var logic      busy,
    input  var logic      done,
    output var logic      start,
    output var dac_word_t tx_word,

    output var logic      initdone,
    output var logic      dac_updated_stb
);

    typedef enum logic [1:0] {
        ST_RESET_DEFAULT,
        ST_IDLE,
        ST_SENDING
    } xfer_state_t;

    xfer_state_t state;
    logic        pending;
    logic        launch;

    ////////////////////////////////////////////////////////////////////////////
    // launch decision

    // launch always carries the register as it is now, so any number of
    // changes seen during a frame collapse into one follow-up
    always_comb begin
        case (state)
            ST_RESET_DEFAULT: launch = 1'b1;
            ST_IDLE:          launch = word_stb;
            ST_SENDING:       launch = done & (pending | word_stb);
            default:          launch = 1'b0;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // state machine

    always_ff @(posedge clk) begin
        if (peripheral_sreset) begin
            state           <= ST_RESET_DEFAULT;
            pending         <= 1'b0;
            start           <= 1'b0;
            initdone        <= 1'b0;
            dac_updated_stb <= 1'b0;
        end else begin
            start           <= launch;
            dac_updated_stb <= done;

            // first frame end marks the default word as written
            if (done) begin
                initdone <= 1'b1;
            end

            case (state)
                ST_RESET_DEFAULT: begin
                    state   <= ST_SENDING;
                    pending <= 1'b0;
                end

                ST_IDLE: begin
                    pending <= 1'b0;
                    if (word_stb) begin
                        state <= ST_SENDING;
                    end
                end

                ST_SENDING: begin
                    if (launch) begin
                        pending <= 1'b0;
                    end else if (word_stb) begin
                        pending <= 1'b1;
                    end
                    if (done && !launch) begin
                        state <= ST_IDLE;
                    end
                end

                default: begin
                    state   <= ST_IDLE;
                    pending <= 1'b0;
                end
            endcase
        end
    end

    // word is sampled in the launch cycle
    always_ff @(posedge clk) begin
        if (launch) begin
            tx_word <= word;
        end
    end

    start_idle_a: assert property (@(posedge clk) disable iff (peripheral_sreset)
        start |-> !busy);

    // a frame end always belongs to a frame this block launched
    done_owned_a: assert property (@(posedge clk) disable iff (peripheral_sreset)
        done |-> state == ST_SENDING);

endmodule

`default_nettype wire

// ==== sim.f ====
design/dac_pkg.sv
design/dac_reg_file.sv
design/dac_xfer_ctrl.sv
design/dac_spi_shifter.sv
design/dac_subsystem_top.sv
bench/tb_clock_gen.sv
bench/dac_subsystem_tb.sv
